// ==== Bender.yml ====
package:
  name: mcsr

sources:
  - include_dirs:
      - design
    files:
      - design/mcsr_pkg.sv
      - design/mcsr_access.sv
      - design/mcsr_trap_ctrl.sv
      - design/mcsr_tvec.sv
      - design/mcsr_plain_regs.sv
      - design/mcsr_top.sv
  - target: simulation
    files:
      - bench/mcsr_checker.sv
      - bench/mcsr_tb.sv

// ==== bench/mcsr_checker.sv ====
// ------------------------------------------------------------------------
// Assertions on the machine-mode CSR block
// Bound to the top level and sampled on the rising clock edge
// ------------------------------------------------------------------------

`timescale 1ns/1ps

module mcsr_checker (
    input logic               g_clk,
    input logic               g_resetn,
    input mcsr_pkg::csr_req_t req,
    input mcsr_pkg::trap_in_t trap,
    input logic               csr_error,
    input logic               mstatus_mie,
    input mcsr_pkg::xlen_t    csr_mtvec
);

    int unsigned fail_count = 0;                  // Failed assertions so far

    // Errors only come from an enabled access
    error_needs_en: assert property (@(posedge g_clk) disable iff (!g_resetn)
        !req.en |-> !csr_error)
        else begin
            $error("csr_error raised without an enabled request");
            fail_count++;
        end

    // Trap entry masks interrupts
    trap_clears_mie: assert property (@(posedge g_clk) disable iff (!g_resetn)
        trap.cpu |=> !mstatus_mie)
        else begin
            $error("mstatus_mie still set in the cycle after a CPU trap");
            fail_count++;
        end

    tvec_word_aligned: assert property (@(posedge g_clk) disable iff (!g_resetn)
        csr_mtvec[1:0] == 2'b00)
        else begin
            $error("csr_mtvec is not word aligned");
            fail_count++;
        end

endmodule

bind mcsr_top mcsr_checker mcsr_checker_i (
    .g_clk(g_clk),
    .g_resetn(g_resetn),
    .req(req),
    .trap(trap),
    .csr_error(csr_error),
    .mstatus_mie(mstatus_mie),
    .csr_mtvec(csr_mtvec)
);

// ==== bench/mcsr_tb.sv ====
// ------------------------------------------------------------------------
// Testbench for the machine-mode CSR block
// Applies a table of CSR accesses, traps and MRETs and checks each cycle
// ------------------------------------------------------------------------

`timescale 1ns/1ps

module mcsr_tb;

    typedef struct packed {
        mcsr_pkg::csr_req_t  req;
        mcsr_pkg::trap_in_t  trap;
        logic                mret;
        mcsr_pkg::irq_bits_t mip;
        mcsr_pkg::xlen_t     exp_rdata;
        logic                exp_error;
        logic                exp_mie;
        logic                exp_vec;
        mcsr_pkg::irq_bits_t exp_irq;
        mcsr_pkg::xlen_t     exp_mepc;
        mcsr_pkg::xlen_t     exp_mtvec;
    } step_t;

    logic                g_clk;
    logic                g_resetn;
    mcsr_pkg::csr_req_t  req;
    mcsr_pkg::trap_in_t  trap;
    logic                exec_mret;
    mcsr_pkg::irq_bits_t mip;
    mcsr_pkg::xlen_t     csr_rdata;
    logic                csr_error;
    mcsr_pkg::xlen_t     csr_mepc;
    mcsr_pkg::xlen_t     csr_mtvec;
    logic                vector_intrs;
    logic                mstatus_mie;
    mcsr_pkg::irq_bits_t mie;

    step_t               steps [0:63];
    int                  n_steps;
    integer              seed;
    mcsr_pkg::xlen_t     rnd [0:2];

    // Reference model of the state seen on the outputs
    logic                model_mie;
    logic                model_vec;
    mcsr_pkg::irq_bits_t model_irq;
    mcsr_pkg::xlen_t     model_scratch;
    mcsr_pkg::xlen_t     model_mepc;
    mcsr_pkg::xlen_t     model_mtvec;

    mcsr_top mcsr_top_i (.*);

    initial begin
        g_clk = 1'b0;
        forever begin
            #4 g_clk = ~g_clk;
        end
    end

    // ------------------------------------------------------------------------
    // Failure reporting and compare tasks
    // ------------------------------------------------------------------------
    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    task automatic compare_word(input string what, input mcsr_pkg::xlen_t got,
                                input mcsr_pkg::xlen_t exp);
        if (got !== exp) begin
            stop_run($sformatf("ERROR %0t: %s is %h, expected %h", $time, what, got, exp));
        end
    endtask

    task automatic compare_bit(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            stop_run($sformatf("ERROR %0t: %s is %b, expected %b", $time, what, got, exp));
        end
    endtask

    task automatic compare_irq(input string what, input mcsr_pkg::irq_bits_t got,
                               input mcsr_pkg::irq_bits_t exp);
        if (got !== exp) begin
            stop_run($sformatf("ERROR %0t: %s is %b, expected %b", $time, what, got, exp));
        end
    endtask

    task automatic check_assertions();
        if (mcsr_top_i.mcsr_checker_i.fail_count != 0) begin
            stop_run("An assertion in the bound checker failed");
        end
    endtask

    // ------------------------------------------------------------------------
    // Table construction
    // ------------------------------------------------------------------------
    function automatic mcsr_pkg::csr_req_t make_req(logic wr, mcsr_pkg::csr_op_t op,
                                                    mcsr_pkg::csr_addr_t addr,
                                                    mcsr_pkg::xlen_t data);
        mcsr_pkg::csr_req_t r;
        r.en        = 1'b1;
        r.wr        = wr;
        r.op        = op;
        r.addr      = addr;
        r.wdata.raw = data;
        return r;
    endfunction

    function automatic mcsr_pkg::trap_in_t make_trap(logic cpu, logic intr, logic [5:0] cause,
                                                     mcsr_pkg::xlen_t tval,
                                                     mcsr_pkg::xlen_t pc);
        mcsr_pkg::trap_in_t t;
        t.cpu   = cpu;
        t.intr  = intr;
        t.cause = cause;
        t.mtval = tval;
        t.pc    = pc;
        return t;
    endfunction

    task automatic add_step(input mcsr_pkg::csr_req_t r, input mcsr_pkg::trap_in_t t,
                            input logic mret, input mcsr_pkg::irq_bits_t p,
                            input mcsr_pkg::xlen_t rd_exp, input logic err_exp);
        steps[n_steps] = '{req: r, trap: t, mret: mret, mip: p, exp_rdata: rd_exp,
                           exp_error: err_exp, exp_mie: model_mie, exp_vec: model_vec,
                           exp_irq: model_irq, exp_mepc: model_mepc,
                           exp_mtvec: model_mtvec};
        n_steps++;
    endtask

    task automatic read_row(input mcsr_pkg::csr_addr_t addr, input mcsr_pkg::xlen_t exp);
        add_step(make_req(1'b0, mcsr_pkg::CSR_OP_WRITE, addr, '0), '0, 1'b0, '0, exp, 1'b0);
    endtask

    // Read data on a write cycle is still the old word
    task automatic write_row(input mcsr_pkg::csr_op_t op, input mcsr_pkg::csr_addr_t addr,
                             input mcsr_pkg::xlen_t data, input mcsr_pkg::xlen_t old,
                             input logic err);
        add_step(make_req(1'b1, op, addr, data), '0, 1'b0, '0, old, err);
    endtask

    task automatic event_row(input mcsr_pkg::trap_in_t t, input logic mret);
        add_step('0, t, mret, '0, '0, 1'b0);
    endtask

    task automatic build_table();
        rnd[0] = $random(seed);
        rnd[1] = $random(seed);
        rnd[2] = $random(seed);
        // Scratch write, set and clear
        write_row(mcsr_pkg::CSR_OP_WRITE, 12'h340, rnd[0], 32'h0, 1'b0);
        model_scratch = rnd[0];
        read_row(12'h340, model_scratch);
        write_row(mcsr_pkg::CSR_OP_SET, 12'h340, rnd[1], model_scratch, 1'b0);
        model_scratch = model_scratch | rnd[1];
        read_row(12'h340, model_scratch);
        write_row(mcsr_pkg::CSR_OP_CLEAR, 12'h340, rnd[2], model_scratch, 1'b0);
        model_scratch = model_scratch & ~rnd[2];
        read_row(12'h340, model_scratch);
        // Unknown address and misa
        write_row(mcsr_pkg::CSR_OP_WRITE, 12'hC00, 32'h1234_5678, 32'h0, 1'b1);
        read_row(12'h340, model_scratch);
        read_row(12'h301, 32'h4000_1106);                  // MXL 1 with B, C, I and M
        // Trap vector
        read_row(12'h305, 32'hC000_0000);
        write_row(mcsr_pkg::CSR_OP_WRITE, 12'h305, 32'h8000_0081, 32'hC000_0000, 1'b0);
        model_vec   = 1'b1;
        model_mtvec = 32'h8000_0080;                       // Mode bits not part of the target
        read_row(12'h305, 32'h8000_0081);
        write_row(mcsr_pkg::CSR_OP_WRITE, 12'h305, 32'h0000_1002, 32'h8000_0081, 1'b1);
        write_row(mcsr_pkg::CSR_OP_WRITE, 12'h305, 32'h0000_1041, 32'h8000_0081, 1'b1);
        read_row(12'h305, 32'h8000_0081);
        // CPU trap, then MRET
        write_row(mcsr_pkg::CSR_OP_SET, 12'h300, 32'h0000_0008, 32'h0, 1'b0);
        model_mie = 1'b1;
        event_row(make_trap(1'b1, 1'b0, 6'd2, 32'hDEAD_BEEF, 32'h0000_2345), 1'b0);
        model_mie  = 1'b0;
        model_mepc = 32'h0000_2344;
        read_row(12'h341, 32'h0000_2344);                  // PC bit 0 dropped
        read_row(12'h342, 32'h0000_0002);
        read_row(12'h343, 32'hDEAD_BEEF);
        read_row(12'h300, 32'h0000_0080);                  // MPIE holds the old MIE
        event_row('0, 1'b1);
        model_mie = 1'b1;
        read_row(12'h300, 32'h0000_0008);
        // Interrupt request held for three cycles
        event_row(make_trap(1'b0, 1'b1, 6'd7, '0, 32'h0000_1000), 1'b0);
        model_mie  = 1'b0;
        model_mepc = 32'h0000_1000;
        event_row(make_trap(1'b0, 1'b1, 6'd7, '0, 32'h0000_1004), 1'b0);
        event_row(make_trap(1'b0, 1'b1, 6'd7, '0, 32'h0000_1008), 1'b0);
        read_row(12'h342, 32'h8000_0007);
        read_row(12'h341, 32'h0000_1000);
        read_row(12'h343, 32'hDEAD_BEEF);
        // Interrupt enables, pending bits and mcause legality
        write_row(mcsr_pkg::CSR_OP_WRITE, 12'h304, 32'h0000_0888, 32'h0, 1'b0);
        model_irq = 3'b111;
        read_row(12'h304, 32'h0000_0888);
        write_row(mcsr_pkg::CSR_OP_CLEAR, 12'h304, 32'h0000_0008, 32'h0000_0888, 1'b0);
        model_irq = 3'b110;
        read_row(12'h304, 32'h0000_0880);
        add_step(make_req(1'b0, mcsr_pkg::CSR_OP_WRITE, 12'h344, '0), '0, 1'b0, 3'b011,
                 32'h0000_0088, 1'b0);
        write_row(mcsr_pkg::CSR_OP_WRITE, 12'h342, 32'h0000_000A, 32'h8000_0007, 1'b0);
        read_row(12'h342, 32'h8000_0007);                  // Code 10 is not supported
        write_row(mcsr_pkg::CSR_OP_WRITE, 12'h342, 32'h0000_000B, 32'h8000_0007, 1'b0);
        read_row(12'h342, 32'h0000_000B);
    endtask

    // ------------------------------------------------------------------------
    // Reset and table playback
    // ------------------------------------------------------------------------
    initial begin
        int wait_cycles;
        seed          = 32'h856d_f42b;
        g_resetn      = 1'b0;
        req           = '0;
        trap          = '0;
        exec_mret     = 1'b0;
        mip           = '0;
        n_steps       = 0;
        model_mie     = 1'b0;
        model_vec     = 1'b0;
        model_irq     = '0;
        model_scratch = '0;
        model_mepc    = '0;
        model_mtvec   = 32'hC000_0000;
        build_table();
        repeat (2) @(posedge g_clk);
        @(negedge g_clk);
        g_resetn    = 1'b1;
        wait_cycles = 0;
        while (csr_mtvec !== 32'hC000_0000 || csr_mepc !== 32'h0) begin
            if (wait_cycles == 10) begin
                stop_run("Reset values did not appear within 10 cycles after reset");
            end else begin
                @(negedge g_clk);
                wait_cycles++;
            end
        end
        for (int i = 0; i < n_steps; i++) begin
            req       = steps[i].req;                      // Driven on the falling edge
            trap      = steps[i].trap;
            exec_mret = steps[i].mret;
            mip       = steps[i].mip;
            #1;
            compare_word($sformatf("step %0d csr_rdata", i), csr_rdata, steps[i].exp_rdata);
            compare_bit($sformatf("step %0d csr_error", i), csr_error, steps[i].exp_error);
            compare_bit($sformatf("step %0d mstatus_mie", i), mstatus_mie, steps[i].exp_mie);
            compare_bit($sformatf("step %0d vector_intrs", i), vector_intrs, steps[i].exp_vec);
            compare_irq($sformatf("step %0d mie", i), mie, steps[i].exp_irq);
            compare_word($sformatf("step %0d csr_mepc", i), csr_mepc, steps[i].exp_mepc);
            compare_word($sformatf("step %0d csr_mtvec", i), csr_mtvec, steps[i].exp_mtvec);
            check_assertions();
            @(negedge g_clk);
        end
        req       = '0;
        trap      = '0;
        exec_mret = 1'b0;
        mip       = '0;
        if (mcsr_top_i.mcsr_checker_i.fail_count == 0) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            stop_run("An assertion in the bound checker failed in the last cycle");
        end
    end

endmodule

// ==== design/mcsr_access.sv ====
// ------------------------------------------------------------------------
// CSR access decoder
// Turns an address into write strobes, selects the read word and flags
// writes to unknown addresses or illegal trap vectors
// ------------------------------------------------------------------------

`timescale 1ns/1ps

`include "mcsr_defines.svh"

module mcsr_access (
    input  mcsr_pkg::csr_req_t  req,
    input  mcsr_pkg::csr_view_t view,
    input  logic                tvec_bad_write,
    output mcsr_pkg::csr_wen_t  wen,
    output mcsr_pkg::xlen_t     rdata,
    output logic                error
);

    logic hit_mstatus;
    logic hit_misa;
    logic hit_mie;
    logic hit_mtvec;
    logic hit_mscratch;
    logic hit_mepc;
    logic hit_mcause;
    logic hit_mtval;
    logic hit_mip;
    logic known_addr;

    // --------------------------------------------------------------------
    // Address decode, qualified by the access enable
    // --------------------------------------------------------------------
    assign hit_mstatus  = req.en && (req.addr == `MCSR_ADDR_MSTATUS);
    assign hit_misa     = req.en && (req.addr == `MCSR_ADDR_MISA);
    assign hit_mie      = req.en && (req.addr == `MCSR_ADDR_MIE);
    assign hit_mtvec    = req.en && (req.addr == `MCSR_ADDR_MTVEC);
    assign hit_mscratch = req.en && (req.addr == `MCSR_ADDR_MSCRATCH);
    assign hit_mepc     = req.en && (req.addr == `MCSR_ADDR_MEPC);
    assign hit_mcause   = req.en && (req.addr == `MCSR_ADDR_MCAUSE);
    assign hit_mtval    = req.en && (req.addr == `MCSR_ADDR_MTVAL);
    assign hit_mip      = req.en && (req.addr == `MCSR_ADDR_MIP);

    assign known_addr = hit_mstatus  ||
                        hit_misa     ||
                        hit_mie      ||
                        hit_mtvec    ||
                        hit_mscratch ||
                        hit_mepc     ||
                        hit_mcause   ||
                        hit_mtval    ||
                        hit_mip;

    // --------------------------------------------------------------------
    // Write strobes
    // --------------------------------------------------------------------
    assign wen.mstatus  = req.wr && hit_mstatus;
    assign wen.mie      = req.wr && hit_mie;
    assign wen.mtvec    = req.wr && hit_mtvec;
    assign wen.mscratch = req.wr && hit_mscratch;
    assign wen.mepc     = req.wr && hit_mepc;
    assign wen.mcause   = req.wr && hit_mcause;
    assign wen.mtval    = req.wr && hit_mtval;

    // misa and mip accept writes silently
    assign error = req.en && ((req.wr && !known_addr) || tvec_bad_write);

    // --------------------------------------------------------------------
    // Read multiplexer
    // --------------------------------------------------------------------
    assign rdata = ({32{hit_mstatus}}  & view.mstatus)     |
                   ({32{hit_misa}}     & `MCSR_MISA_VALUE) |
                   ({32{hit_mie}}      & view.mie)         |
                   ({32{hit_mtvec}}    & view.mtvec)       |
                   ({32{hit_mscratch}} & view.mscratch)    |
                   ({32{hit_mepc}}     & view.mepc)        |
                   ({32{hit_mcause}}   & view.mcause)      |
                   ({32{hit_mtval}}    & view.mtval)       |
                   ({32{hit_mip}}      & view.mip);

endmodule

// ==== design/mcsr_defines.svh ====
// ------------------------------------------------------------------------
// Machine-mode CSR constants
// Register addresses, misa contents, bit positions and trap cause codes
// ------------------------------------------------------------------------

`ifndef MCSR_DEFINES_SVH
`define MCSR_DEFINES_SVH

// ------------------------------------------------------------------------
// Register addresses
// ------------------------------------------------------------------------
`define MCSR_ADDR_MSTATUS   12'h300
`define MCSR_ADDR_MISA      12'h301
`define MCSR_ADDR_MIE       12'h304
`define MCSR_ADDR_MTVEC     12'h305
`define MCSR_ADDR_MSCRATCH  12'h340
`define MCSR_ADDR_MEPC      12'h341
`define MCSR_ADDR_MCAUSE    12'h342
`define MCSR_ADDR_MTVAL     12'h343
`define MCSR_ADDR_MIP       12'h344

// Direct mode, base in the top of the address map
`define MCSR_MTVEC_RESET    32'hC000_0000

// MXL = 1, extensions M, I, C and B
`define MCSR_MISA_VALUE     32'h4000_1106

// ------------------------------------------------------------------------
// Bit positions
// ------------------------------------------------------------------------
`define MCSR_BIT_MIE        3         // mstatus
`define MCSR_BIT_MPIE       7         // mstatus
`define MCSR_BIT_MSI        3         // mie / mip
`define MCSR_BIT_MTI        7         // mie / mip
`define MCSR_BIT_MEI        11        // mie / mip

// Synchronous trap causes accepted by an mcause write
`define MCSR_CAUSE_IALIGN   6'd0      // Fetch misaligned
`define MCSR_CAUSE_IACCESS  6'd1      // Fetch access fault
`define MCSR_CAUSE_IOPCODE  6'd2      // Illegal opcode
`define MCSR_CAUSE_BREAKPT  6'd3
`define MCSR_CAUSE_LDALIGN  6'd4
`define MCSR_CAUSE_LDACCESS 6'd5
`define MCSR_CAUSE_STALIGN  6'd6
`define MCSR_CAUSE_STACCESS 6'd7
`define MCSR_CAUSE_ECALLM   6'd11     // Environment call from M-mode

`endif

// ==== design/mcsr_pkg.sv ====
// ------------------------------------------------------------------------
// Machine-mode CSR types
// Request, strobe and view structures plus the read-modify-write helper
// ------------------------------------------------------------------------

package mcsr_pkg;

    typedef logic [31:0] xlen_t;
    typedef logic [11:0] csr_addr_t;

    typedef enum logic [1:0] {
        CSR_OP_WRITE = 2'd0,
        CSR_OP_SET   = 2'd1,
        CSR_OP_CLEAR = 2'd2
    } csr_op_t;

    // Two decodings of one data word
    typedef struct packed {
        logic [29:0] base;
        logic [1:0]  mode;
    } vec_view_t;

    typedef struct packed {
        logic        intr;
        logic [30:0] code;
    } cause_view_t;

    typedef union packed {
        xlen_t       raw;
        vec_view_t   vec;
        cause_view_t cause;
    } csr_word_u;

    typedef struct packed {
        logic      en;
        logic      wr;
        csr_op_t   op;
        csr_addr_t addr;
        csr_word_u wdata;
    } csr_req_t;

    typedef struct packed {
        logic mstatus;
        logic mie;
        logic mtvec;
        logic mscratch;
        logic mepc;
        logic mcause;
        logic mtval;
    } csr_wen_t;

    typedef struct packed {
        xlen_t mstatus;
        xlen_t mie;
        xlen_t mip;
        xlen_t mtvec;
        xlen_t mscratch;
        xlen_t mepc;
        xlen_t mcause;
        xlen_t mtval;
    } csr_view_t;

    typedef struct packed {
        logic        cpu;
        logic        intr;
        logic [5:0]  cause;
        xlen_t       mtval;
        xlen_t       pc;
    } trap_in_t;

    typedef struct packed {
        logic mei;
        logic mti;
        logic msi;
    } irq_bits_t;

    function automatic xlen_t mcsr_modify(csr_op_t op, xlen_t old_word, xlen_t wdata);
        xlen_t result;
        case (op)
            CSR_OP_SET:   result = old_word | wdata;
            CSR_OP_CLEAR: result = old_word & ~wdata;
            default:      result = wdata;
        endcase
        return result;
    endfunction

endpackage

// ==== design/mcsr_plain_regs.sv ====
// ------------------------------------------------------------------------
// Interrupt enable and scratch registers
// Also places the pending interrupt inputs into the mip word
// ------------------------------------------------------------------------

`timescale 1ns/1ps

`include "mcsr_defines.svh"

module mcsr_plain_regs (
    input  logic                g_clk,
    input  logic                g_resetn,
    input  mcsr_pkg::csr_req_t  req,
    input  mcsr_pkg::csr_wen_t  wen,
    input  mcsr_pkg::irq_bits_t mip,
    output mcsr_pkg::irq_bits_t mie,
    output mcsr_pkg::xlen_t     mie_word,
    output mcsr_pkg::xlen_t     mip_word,
    output mcsr_pkg::xlen_t     scratch_word
);

    mcsr_pkg::irq_bits_t mie_q;
    mcsr_pkg::xlen_t     scratch_q;
    mcsr_pkg::xlen_t     mie_new;

    // Same layout for mie and mip
    function automatic mcsr_pkg::xlen_t place_irq(mcsr_pkg::irq_bits_t bits);
        mcsr_pkg::xlen_t word;
        word               = '0;
        word[`MCSR_BIT_MEI] = bits.mei;
        word[`MCSR_BIT_MTI] = bits.mti;
        word[`MCSR_BIT_MSI] = bits.msi;
        return word;
    endfunction

    assign mie_new = mcsr_pkg::mcsr_modify(req.op, mie_word, req.wdata.raw);

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            mie_q     <= '0;
            scratch_q <= '0;
        end else begin
            if (wen.mie) begin
                mie_q <= '{mei: mie_new[`MCSR_BIT_MEI],
                           mti: mie_new[`MCSR_BIT_MTI],
                           msi: mie_new[`MCSR_BIT_MSI]};
            end
            if (wen.mscratch) begin
                scratch_q <= mcsr_pkg::mcsr_modify(req.op, scratch_q, req.wdata.raw);
            end
        end
    end

    assign mie          = mie_q;
    assign mie_word     = place_irq(mie_q);
    assign mip_word     = place_irq(mip);
    assign scratch_word = scratch_q;

endmodule

// ==== design/mcsr_top.sv ====
// ------------------------------------------------------------------------
// Machine-mode CSR block
// Connects the access decoder to the trap, vector and plain registers
// ------------------------------------------------------------------------

`timescale 1ns/1ps

module mcsr_top (
    input  logic                g_clk,
    input  logic                g_resetn,
    input  mcsr_pkg::csr_req_t  req,
    input  mcsr_pkg::trap_in_t  trap,
    input  logic                exec_mret,
    input  mcsr_pkg::irq_bits_t mip,
    output mcsr_pkg::xlen_t     csr_rdata,
    output logic                csr_error,
    output mcsr_pkg::xlen_t     csr_mepc,
    output mcsr_pkg::xlen_t     csr_mtvec,
    output logic                vector_intrs,
    output logic                mstatus_mie,
    output mcsr_pkg::irq_bits_t mie
);

    mcsr_pkg::csr_wen_t  wen;
    mcsr_pkg::csr_view_t view;
    logic                tvec_bad_write;
    mcsr_pkg::xlen_t     status_word;
    mcsr_pkg::xlen_t     mepc_word;
    mcsr_pkg::xlen_t     mcause_word;
    mcsr_pkg::xlen_t     mtval_word;
    mcsr_pkg::xlen_t     tvec_word;
    mcsr_pkg::xlen_t     mie_word;
    mcsr_pkg::xlen_t     mip_word;
    mcsr_pkg::xlen_t     scratch_word;

    // Register words seen by the read multiplexer
    assign view = '{mstatus:  status_word,
                    mie:      mie_word,
                    mip:      mip_word,
                    mtvec:    tvec_word,
                    mscratch: scratch_word,
                    mepc:     mepc_word,
                    mcause:   mcause_word,
                    mtval:    mtval_word};

    mcsr_access access_i (
        .req(req), .view(view), .tvec_bad_write(tvec_bad_write),
        .wen(wen), .rdata(csr_rdata), .error(csr_error)
    );

    mcsr_trap_ctrl trap_ctrl_i (
        .g_clk(g_clk), .g_resetn(g_resetn), .req(req), .wen(wen), .trap(trap),
        .exec_mret(exec_mret), .mstatus_mie(mstatus_mie), .mepc(csr_mepc),
        .status_word(status_word), .mepc_word(mepc_word),
        .mcause_word(mcause_word), .mtval_word(mtval_word)
    );

    mcsr_tvec tvec_i (
        .g_clk(g_clk), .g_resetn(g_resetn), .req(req), .wen_tvec(wen.mtvec),
        .mtvec(csr_mtvec), .vector_intrs(vector_intrs), .tvec_word(tvec_word),
        .bad_write(tvec_bad_write)
    );

    mcsr_plain_regs plain_regs_i (
        .g_clk(g_clk), .g_resetn(g_resetn), .req(req), .wen(wen), .mip(mip),
        .mie(mie), .mie_word(mie_word), .mip_word(mip_word),
        .scratch_word(scratch_word)
    );

endmodule

// ==== design/mcsr_trap_ctrl.sv ====
// ------------------------------------------------------------------------
// Trap controller
// Holds mstatus, mepc, mcause and mtval and updates them on trap entry,
// MRET and CSR writes
// ------------------------------------------------------------------------

`timescale 1ns/1ps

`include "mcsr_defines.svh"

module mcsr_trap_ctrl (
    input  logic               g_clk,
    input  logic               g_resetn,
    input  mcsr_pkg::csr_req_t req,
    input  mcsr_pkg::csr_wen_t wen,
    input  mcsr_pkg::trap_in_t trap,
    input  logic               exec_mret,
    output logic               mstatus_mie,
    output mcsr_pkg::xlen_t    mepc,
    output mcsr_pkg::xlen_t    status_word,
    output mcsr_pkg::xlen_t    mepc_word,
    output mcsr_pkg::xlen_t    mcause_word,
    output mcsr_pkg::xlen_t    mtval_word
);

    logic                intr_q;
    logic                int_pulse;
    logic                trap_any;
    logic                mie_q;
    logic                mpie_q;
    logic [7:0]          wpri1_q;
    logic [1:0]          wpri2_q;
    logic                wpri3_q;
    logic                wpri4_q;
    logic [30:0]         mepc_q;
    mcsr_pkg::csr_word_u cause_q;
    mcsr_pkg::xlen_t     mtval_q;
    mcsr_pkg::xlen_t     status_new;
    mcsr_pkg::xlen_t     mepc_new;
    mcsr_pkg::csr_word_u cause_new;
    mcsr_pkg::xlen_t     mtval_new;
    logic                cause_legal;

    // Interrupt is taken on its first cycle only
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            intr_q <= 1'b0;
        end else begin
            intr_q <= trap.intr;
        end
    end

    assign int_pulse = trap.intr && !intr_q;
    assign trap_any  = int_pulse || trap.cpu;

    assign status_new    = mcsr_pkg::mcsr_modify(req.op, status_word, req.wdata.raw);
    assign mepc_new      = mcsr_pkg::mcsr_modify(req.op, mepc_word, req.wdata.raw);
    assign cause_new.raw = mcsr_pkg::mcsr_modify(req.op, cause_q.raw, req.wdata.raw);
    assign mtval_new     = mcsr_pkg::mcsr_modify(req.op, mtval_q, req.wdata.raw);

    // Only synchronous codes from the supported list may be written
    always_comb begin
        cause_legal = 1'b0;
        if (!cause_new.cause.intr && (cause_new.cause.code[30:6] == '0)) begin
            case (cause_new.cause.code[5:0])
                `MCSR_CAUSE_IALIGN,  `MCSR_CAUSE_IACCESS,  `MCSR_CAUSE_IOPCODE,
                `MCSR_CAUSE_BREAKPT, `MCSR_CAUSE_LDALIGN,  `MCSR_CAUSE_LDACCESS,
                `MCSR_CAUSE_STALIGN, `MCSR_CAUSE_STACCESS, `MCSR_CAUSE_ECALLM:
                    cause_legal = 1'b1;
                default:
                    cause_legal = 1'b0;
            endcase
        end
    end

    // --------------------------------------------------------------------
    // mstatus
    // --------------------------------------------------------------------
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            mie_q   <= 1'b0;
            mpie_q  <= 1'b0;
            wpri1_q <= '0;
            wpri2_q <= '0;
            wpri3_q <= 1'b0;
            wpri4_q <= 1'b0;
        end else if (trap_any) begin
            mpie_q <= mie_q;                          // Stack the enable
            mie_q  <= 1'b0;
        end else if (exec_mret) begin
            mie_q  <= mpie_q;
            mpie_q <= 1'b0;
        end else if (wen.mstatus) begin
            mie_q   <= status_new[`MCSR_BIT_MIE];
            mpie_q  <= status_new[`MCSR_BIT_MPIE];
            wpri1_q <= status_new[30:23];
            wpri2_q <= status_new[10:9];
            wpri3_q <= status_new[6];
            wpri4_q <= status_new[2];
        end
    end

    // --------------------------------------------------------------------
    // mepc, mcause and mtval
    // --------------------------------------------------------------------
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            mepc_q      <= '0;
            cause_q.raw <= '0;
            mtval_q     <= '0;
        end else begin
            if (trap_any) begin
                mepc_q      <= trap.pc[31:1];
                cause_q.raw <= {int_pulse, 25'b0, trap.cause};
            end else begin
                if (wen.mepc) begin
                    mepc_q <= mepc_new[31:1];
                end
                if (wen.mcause && cause_legal) begin
                    cause_q <= cause_new;
                end
            end
            if (trap.cpu && !int_pulse) begin
                mtval_q <= trap.mtval;                // Faulting address or opcode
            end else if (wen.mtval && !int_pulse) begin
                mtval_q <= mtval_new;
            end
        end
    end

    assign status_word = {1'b0, wpri1_q, 12'b0, wpri2_q, 1'b0, mpie_q, wpri3_q,
                          2'b0, mie_q, wpri4_q, 2'b0};
    assign mstatus_mie = mie_q;
    assign mepc_word   = {mepc_q, 1'b0};
    assign mepc        = mepc_word;
    assign mcause_word = cause_q.raw;
    assign mtval_word  = mtval_q;

endmodule

// ==== design/mcsr_tvec.sv ====
// ------------------------------------------------------------------------
// Trap vector register
// Holds mtvec and rejects modes or bases the core cannot vector to
// ------------------------------------------------------------------------

`timescale 1ns/1ps

`include "mcsr_defines.svh"

module mcsr_tvec (
    input  logic               g_clk,
    input  logic               g_resetn,
    input  mcsr_pkg::csr_req_t req,
    input  logic               wen_tvec,
    output mcsr_pkg::xlen_t    mtvec,
    output logic               vector_intrs,
    output mcsr_pkg::xlen_t    tvec_word,
    output logic               bad_write
);

    mcsr_pkg::csr_word_u tvec_q;
    mcsr_pkg::csr_word_u tvec_new;

    assign tvec_new.raw = mcsr_pkg::mcsr_modify(req.op, tvec_q.raw, req.wdata.raw);

    // Modes 2 and 3 are reserved, vectored mode needs a 128-byte aligned base
    assign bad_write = wen_tvec && (tvec_new.vec.mode[1] ||
                                    (tvec_new.vec.mode[0] && |tvec_new.vec.base[4:0]));

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            tvec_q.raw <= `MCSR_MTVEC_RESET;
        end else if (wen_tvec && !bad_write) begin
            tvec_q <= tvec_new;
        end
    end

    assign mtvec        = {tvec_q.vec.base, 2'b00};  // Word aligned target
    assign vector_intrs = tvec_q.vec.mode[0];
    assign tvec_word    = tvec_q.raw;

endmodule

// ==== src.f ====
+incdir+design
design/mcsr_pkg.sv
design/mcsr_access.sv
design/mcsr_trap_ctrl.sv
design/mcsr_tvec.sv
design/mcsr_plain_regs.sv
design/mcsr_top.sv
bench/mcsr_checker.sv
bench/mcsr_tb.sv
